/* all.f */
verilog/fe_pkg.sv
verilog/inst_mem.sv
verilog/imem_arbiter.sv
verilog/fetch_unit.sv
verilog/ibuffer.sv
verilog/decode_stage.sv
verilog/frontend_top.sv
test/clk_rst_gen.sv
test/frontend_tb.sv

/* test/clk_rst_gen.sv */
// testbench clock of 10 ns and an active-low reset held for the first cycles
module clk_rst_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release a little after the edge, like all other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* test/frontend_tb.sv */
// top-level testbench that loads a program into the front end and checks decode and redirect
module frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_ENTRIES = 14;
  localparam int          PROG_ROWS   = 6;
  localparam int          TIMEOUT     = 400;
  localparam logic [6:0]  OPC_REG     = 7'b0110011;
  localparam logic [6:0]  OPC_IMM     = 7'b0010011;

  logic             clk;
  logic             rst_n;
  logic             start_i;
  logic             load_valid_i;
  logic [4:0]       load_row_i;
  logic [63:0]      load_data_i;
  logic             load_ready_o;
  logic             redirect_i;
  logic [31:0]      redirect_pc_i;
  logic             dec_ready_i;
  logic             dec_valid_o;
  logic [1:0]       dec_slot_valid_o;
  logic [1:0][31:0] dec_pc_o;
  logic [1:0][4:0]  dec_rd_o;
  logic [1:0][4:0]  dec_rs1_o;
  logic [1:0][4:0]  dec_rs2_o;
  logic [1:0][31:0] dec_imm_o;
  logic [1:0]       dec_is_imm_o;
  logic             rand_mode;

  // one row per slot with pc, format and expected decode fields
  logic [31:0] tab_pc  [NUM_ENTRIES];
  logic        tab_imm [NUM_ENTRIES];
  logic [4:0]  tab_rd  [NUM_ENTRIES];
  logic [4:0]  tab_rs1 [NUM_ENTRIES];
  logic [4:0]  tab_rs2 [NUM_ENTRIES];
  logic [31:0] tab_val [NUM_ENTRIES];

  clk_rst_gen u_clk_rst_gen (.clk_o (clk), .rst_no (rst_n));

  frontend_top u_frontend_top (
    .clk_i (clk), .rst_ni (rst_n), .start_i, .load_valid_i, .load_row_i, .load_data_i,
    .load_ready_o, .redirect_i, .redirect_pc_i, .dec_ready_i, .dec_valid_o,
    .dec_slot_valid_o, .dec_pc_o, .dec_rd_o, .dec_rs1_o, .dec_rs2_o, .dec_imm_o,
    .dec_is_imm_o
  );

  // downstream ready is random only during the back-pressure run
  initial begin
    void'($urandom(48));
    forever begin
      @(posedge clk);
      #1 dec_ready_i = rand_mode ? ($urandom % 5 < 2) : 1'b1;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic add_entry(input int i, input logic [31:0] pc, input logic is_imm,
                           input int rd, input int rs1, input int rs2, input int imm);
    tab_pc[i]  = pc;
    tab_imm[i] = is_imm;
    tab_rd[i]  = 5'(rd);
    tab_rs1[i] = 5'(rs1);
    tab_rs2[i] = 5'(rs2);
    tab_val[i] = imm;
  endtask

  // build the instruction word from the expected fields
  function automatic logic [31:0] encode(input int i);
    if (tab_imm[i]) begin
      return {tab_val[i][11:0], tab_rs1[i], 3'b000, tab_rd[i], OPC_IMM};
    end
    return {7'b0000000, tab_rs2[i], tab_rs1[i], 3'b000, tab_rd[i], OPC_REG};
  endfunction

  task automatic load_row(input int row, input logic [63:0] data);
    int cycles;
    @(posedge clk);
    #1;
    load_valid_i = 1'b1;
    load_row_i   = 5'(row);
    load_data_i  = data;
    cycles       = 0;
    @(negedge clk);
    while (!load_ready_o && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!load_ready_o) begin
      abort_run($sformatf("loader write to row %0d was never accepted", row));
    end
    check(u_frontend_top.fetch_gnt, 1'b0, "fetch grant during load");
  endtask

  task automatic redirect_to(input logic [31:0] pc);
    @(posedge clk);
    #1;
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    @(posedge clk);
    #1 redirect_i = 1'b0;
  endtask

  // entries first to last must come out in pc order
  task automatic collect(input int first, input int last);
    int idx;
    int cycles;
    idx    = first;
    cycles = 0;
    while (idx <= last) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("decoded instruction at pc %h never came out", tab_pc[idx]));
      end
      if (dec_valid_o && dec_ready_i) begin
        for (int s = 0; s < 2; s++) begin
          if (dec_slot_valid_o[s] && idx <= last) begin
            check(dec_pc_o[s], tab_pc[idx], $sformatf("pc of slot %0d", s));
            check(dec_rd_o[s], tab_rd[idx], $sformatf("rd at pc %h", tab_pc[idx]));
            check(dec_rs1_o[s], tab_rs1[idx], $sformatf("rs1 at pc %h", tab_pc[idx]));
            check(dec_rs2_o[s], tab_rs2[idx], $sformatf("rs2 at pc %h", tab_pc[idx]));
            check(dec_imm_o[s], tab_val[idx], $sformatf("imm at pc %h", tab_pc[idx]));
            check(dec_is_imm_o[s], tab_imm[idx], $sformatf("is_imm at pc %h", tab_pc[idx]));
            idx++;
          end
        end
      end
    end
  endtask

  initial begin
    start_i       = 1'b0;
    load_valid_i  = 1'b0;
    load_row_i    = '0;
    load_data_i   = '0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    dec_ready_i   = 1'b1;
    rand_mode     = 1'b0;

    add_entry(0,  32'h00, 1'b1, 1,  0,  0,  5);
    add_entry(1,  32'h04, 1'b1, 2,  0,  0,  -1);
    add_entry(2,  32'h08, 1'b0, 3,  1,  2,  0);
    add_entry(3,  32'h0c, 1'b1, 4,  3,  0,  2047);
    add_entry(4,  32'h10, 1'b1, 5,  4,  0,  -2048);
    add_entry(5,  32'h14, 1'b0, 6,  5,  4,  0);
    add_entry(6,  32'h18, 1'b0, 7,  6,  1,  0);
    add_entry(7,  32'h1c, 1'b1, 8,  7,  0,  100);
    add_entry(8,  32'h20, 1'b1, 9,  8,  0,  -37);
    add_entry(9,  32'h24, 1'b0, 10, 9,  8,  0);
    add_entry(10, 32'h28, 1'b1, 11, 10, 0,  291);
    add_entry(11, 32'h2c, 1'b0, 12, 11, 10, 0);
    // new contents of row 1 for the rewrite
    add_entry(12, 32'h08, 1'b1, 20, 21, 0,  -100);
    add_entry(13, 32'h0c, 1'b0, 22, 23, 24, 0);

    for (int c = 0; c < 20 && rst_n !== 1'b1; c++) begin
      @(posedge clk);
    end
    if (rst_n !== 1'b1) begin
      abort_run("reset was never released");
    end
    @(negedge clk);
    check(dec_valid_o, 1'b0, "dec_valid_o after reset");
    check(load_ready_o, 1'b0, "load_ready_o after reset");
    check(u_frontend_top.fetch_req, 1'b0, "fetch request before start");

    for (int r = 0; r < PROG_ROWS; r++) begin
      load_row(r, {encode(2 * r + 1), encode(2 * r)});
    end
    @(posedge clk);
    #1 load_valid_i = 1'b0;

    // in-order decode with the output always ready
    @(posedge clk);
    #1 start_i = 1'b1;
    @(posedge clk);
    #1 start_i = 1'b0;
    collect(0, NUM_ENTRIES - 3);

    rand_mode = 1'b1;
    redirect_to(32'h00);
    collect(0, NUM_ENTRIES - 3);
    rand_mode = 1'b0;

    // second slot of row 2
    redirect_to(32'h14);
    collect(5, NUM_ENTRIES - 3);

    load_row(1, {encode(13), encode(12)});
    @(posedge clk);
    #1 load_valid_i = 1'b0;
    redirect_to(32'h08);
    collect(12, 13);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* verilog/decode_stage.sv */
// registered two-wide decode of register and immediate fields
module decode_stage (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              flush_i,
  input  logic                                              in_valid_i,
  output logic                                              in_ready_o,
  input  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] in_instrs_i,
  input  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] in_pcs_i,
  input  logic [fe_pkg::DECODE_WIDTH-1:0]                   in_slot_valid_i,
  input  logic                                              dec_ready_i,
  output logic                                              dec_valid_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0]                   dec_slot_valid_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] dec_pc_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rd_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rs1_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rs2_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] dec_imm_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0]                   dec_is_imm_o
);

  logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              rd_d;
  logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              rs1_d;
  logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              rs2_d;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] imm_d;
  logic [fe_pkg::DECODE_WIDTH-1:0]                   is_imm_d;
  logic                                              load;

  assign in_ready_o = !dec_valid_o || dec_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_comb begin
    fe_pkg::rv_instr_u w;
    for (int i = 0; i < fe_pkg::DECODE_WIDTH; i++) begin
      w           = in_instrs_i[i];
      is_imm_d[i] = (w.i_fmt.opcode == fe_pkg::OPC_OP_IMM);
      rd_d[i]     = w.r_fmt.rd;
      rs1_d[i]    = w.r_fmt.rs1;
      rs2_d[i]    = (w.r_fmt.opcode == fe_pkg::OPC_OP) ? w.r_fmt.rs2 : 5'd0;
      // 12-bit immediate, sign-extended
      imm_d[i]    = is_imm_d[i] ? {{(fe_pkg::ILEN - 12){w.i_fmt.imm[11]}}, w.i_fmt.imm} : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o      <= 1'b0;
      dec_slot_valid_o <= '0;
    end else if (flush_i) begin
      dec_valid_o      <= 1'b0;
      dec_slot_valid_o <= '0;
    end else if (in_ready_o) begin
      dec_valid_o      <= in_valid_i;
      dec_slot_valid_o <= in_valid_i ? in_slot_valid_i : '0;
    end
  end

  // fields stay put while downstream stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      dec_pc_o     <= in_pcs_i;
      dec_rd_o     <= rd_d;
      dec_rs1_o    <= rs1_d;
      dec_rs2_o    <= rs2_d;
      dec_imm_o    <= imm_d;
      dec_is_imm_o <= is_imm_d;
    end
  end

endmodule

/* verilog/fe_pkg.sv */
// shared widths, opcodes and instruction formats, referenced by every front-end module
package fe_pkg;

  localparam int unsigned ILEN         = 32;
  localparam int unsigned PLEN         = 32;
  localparam int unsigned FETCH_WIDTH  = 2;
  localparam int unsigned DECODE_WIDTH = 2;
  localparam int unsigned IB_DEPTH     = 8;
  localparam int unsigned MEM_ROWS     = 32;
  localparam int unsigned ROW_AW       = 5;
  // byte offset bits inside one memory row
  localparam int unsigned ROW_OFS_W    = $clog2(FETCH_WIDTH * ILEN / 8);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // one instruction word seen as register-register or as immediate format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } rv_instr_u;

endpackage

/* verilog/fetch_unit.sv */
// sequential row fetch with redirect and a holding register that feeds the instruction buffer
module fetch_unit (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             start_i,
  input  logic                                             redirect_i,
  input  logic [fe_pkg::PLEN-1:0]                          redirect_pc_i,
  input  logic                                             gnt_i,
  input  logic                                             rvalid_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rdata_i,
  input  logic                                             fe_ready_i,
  output logic                                             req_o,
  output logic [fe_pkg::ROW_AW-1:0]                        row_o,
  output logic                                             fe_valid_o,
  output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] fe_instrs_o,
  output logic [fe_pkg::PLEN-1:0]                          fe_pc_o,
  output logic [fe_pkg::FETCH_WIDTH-1:0]                   fe_slot_valid_o
);

  logic                    started_q;
  logic [fe_pkg::PLEN-1:0] pc_q;
  logic [fe_pkg::PLEN-1:0] rsp_pc_q;

  assign row_o = pc_q[fe_pkg::ROW_OFS_W +: fe_pkg::ROW_AW];
  // one read in flight at most, and only into a free or freeing holding register
  assign req_o = started_q && !redirect_i && !rvalid_i && (!fe_valid_o || fe_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q   <= 1'b0;
      pc_q        <= '0;
      fe_valid_o  <= 1'b0;
    end else begin
      started_q <= started_q || start_i;
      if (redirect_i) begin
        pc_q       <= redirect_pc_i;
        fe_valid_o <= 1'b0;
      end else begin
        if (gnt_i) begin
          pc_q        <= {pc_q[fe_pkg::PLEN-1:fe_pkg::ROW_OFS_W] + 1'b1,
                          {fe_pkg::ROW_OFS_W{1'b0}}};
        end
        if (rvalid_i) begin
          fe_valid_o <= 1'b1;
        end else if (fe_ready_i) begin
          fe_valid_o <= 1'b0;
        end
      end
    end
  end

  // holding register masks off slots before the fetch pc
  // a return that meets a redirect is stale and never lands here
  always_ff @(posedge clk_i) begin
    if (gnt_i) begin
      rsp_pc_q <= pc_q;
    end
    if (rvalid_i && !redirect_i) begin
      fe_instrs_o <= rdata_i;
      fe_pc_o     <= {rsp_pc_q[fe_pkg::PLEN-1:fe_pkg::ROW_OFS_W], {fe_pkg::ROW_OFS_W{1'b0}}};
      for (int i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
        fe_slot_valid_o[i] <= (i >= int'(rsp_pc_q[fe_pkg::ROW_OFS_W-1:2]));
      end
    end
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fe_valid_o && !fe_ready_i && !redirect_i |=> fe_valid_o && $stable(fe_pc_o));

endmodule

/* verilog/frontend_top.sv */
// front-end top level, connects memory, arbiter, fetch, buffer and decode
module frontend_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              start_i,
  input  logic                                              load_valid_i,
  input  logic [fe_pkg::ROW_AW-1:0]                         load_row_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0]  load_data_i,
  output logic                                              load_ready_o,
  input  logic                                              redirect_i,
  input  logic [fe_pkg::PLEN-1:0]                           redirect_pc_i,
  input  logic                                              dec_ready_i,
  output logic                                              dec_valid_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0]                   dec_slot_valid_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] dec_pc_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rd_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rs1_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][4:0]              dec_rs2_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] dec_imm_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0]                   dec_is_imm_o
);

  logic                                              fetch_req;
  logic                                              fetch_gnt;
  logic                                              fetch_rvalid;
  logic [fe_pkg::ROW_AW-1:0]                         fetch_row;
  logic                                              mem_en;
  logic                                              mem_we;
  logic [fe_pkg::ROW_AW-1:0]                         mem_row;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0]  mem_wdata;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0]  mem_rdata;
  logic                                              fe_valid;
  logic                                              fe_ready;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0]  fe_instrs;
  logic [fe_pkg::PLEN-1:0]                           fe_pc;
  logic [fe_pkg::FETCH_WIDTH-1:0]                    fe_slot_valid;
  logic                                              ibuf_valid;
  logic                                              ibuf_ready;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] ibuf_instrs;
  logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] ibuf_pcs;
  logic [fe_pkg::DECODE_WIDTH-1:0]                   ibuf_slot_valid;

  imem_arbiter u_imem_arbiter (
    .clk_i, .rst_ni, .load_valid_i, .load_row_i, .load_data_i, .load_ready_o,
    .fetch_req_i (fetch_req), .fetch_row_i (fetch_row), .fetch_gnt_o (fetch_gnt),
    .rvalid_o    (fetch_rvalid),
    .mem_en_o    (mem_en), .mem_we_o (mem_we), .mem_row_o (mem_row),
    .mem_wdata_o (mem_wdata)
  );

  inst_mem u_inst_mem (
    .clk_i, .en_i (mem_en), .we_i (mem_we), .row_i (mem_row),
    .wdata_i (mem_wdata), .rdata_o (mem_rdata)
  );

  fetch_unit u_fetch_unit (
    .clk_i, .rst_ni, .start_i, .redirect_i, .redirect_pc_i,
    .gnt_i (fetch_gnt), .rvalid_i (fetch_rvalid), .rdata_i (mem_rdata),
    .fe_ready_i (fe_ready), .req_o (fetch_req), .row_o (fetch_row),
    .fe_valid_o (fe_valid), .fe_instrs_o (fe_instrs), .fe_pc_o (fe_pc),
    .fe_slot_valid_o (fe_slot_valid)
  );

  // redirect also flushes everything between fetch and the decode outputs
  ibuffer #(.IB_DEPTH (fe_pkg::IB_DEPTH)) u_ibuffer (
    .clk_i, .rst_ni, .flush_i (redirect_i),
    .fe_valid_i (fe_valid), .fe_ready_o (fe_ready), .fe_instrs_i (fe_instrs),
    .fe_pc_i (fe_pc), .fe_slot_valid_i (fe_slot_valid),
    .ibuf_valid_o (ibuf_valid), .ibuf_ready_i (ibuf_ready), .ibuf_instrs_o (ibuf_instrs),
    .ibuf_pcs_o (ibuf_pcs), .ibuf_slot_valid_o (ibuf_slot_valid)
  );

  decode_stage u_decode_stage (
    .clk_i, .rst_ni, .flush_i (redirect_i),
    .in_valid_i (ibuf_valid), .in_ready_o (ibuf_ready), .in_instrs_i (ibuf_instrs),
    .in_pcs_i (ibuf_pcs), .in_slot_valid_i (ibuf_slot_valid), .dec_ready_i,
    .dec_valid_o, .dec_slot_valid_o, .dec_pc_o, .dec_rd_o, .dec_rs1_o, .dec_rs2_o,
    .dec_imm_o, .dec_is_imm_o
  );

endmodule

/* verilog/ibuffer.sv */
// instruction FIFO between fetch and decode, compacts groups and bypasses when short
module ibuffer #(
  parameter int unsigned IB_DEPTH = fe_pkg::IB_DEPTH
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              fe_valid_i,
  output logic                                              fe_ready_o,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0]  fe_instrs_i,
  input  logic [fe_pkg::PLEN-1:0]                           fe_pc_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0]                    fe_slot_valid_i,
  output logic                                              ibuf_valid_o,
  input  logic                                              ibuf_ready_i,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::ILEN-1:0] ibuf_instrs_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0][fe_pkg::PLEN-1:0] ibuf_pcs_o,
  output logic [fe_pkg::DECODE_WIDTH-1:0]                   ibuf_slot_valid_o,
  input  logic                                              flush_i
);

  localparam int unsigned PTR_W = $clog2(IB_DEPTH);
  localparam int unsigned CNT_W = $clog2(IB_DEPTH + 1);

  initial assert (IB_DEPTH > 1 && (IB_DEPTH & (IB_DEPTH - 1)) == 0)
    else $fatal(1, "IB_DEPTH must be a power of two");

  logic [fe_pkg::ILEN-1:0] instr_mem [IB_DEPTH];
  logic [fe_pkg::PLEN-1:0] pc_mem    [IB_DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [CNT_W-1:0]        count_q;

  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] cmp_instrs;
  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::PLEN-1:0] cmp_pcs;
  logic [CNT_W-1:0] cmp_cnt;
  logic [CNT_W-1:0] push_cnt;
  logic [CNT_W-1:0] avail_cnt;
  logic [CNT_W-1:0] out_cnt;
  logic [CNT_W-1:0] pop_cnt;
  logic [CNT_W-1:0] pop_q_cnt;
  logic [CNT_W-1:0] byp_cnt;
  logic [CNT_W-1:0] push_q_cnt;
  logic             fe_fire;

  // squeeze valid slots to the front, pc per slot
  always_comb begin
    cmp_cnt    = '0;
    cmp_instrs = '0;
    cmp_pcs    = '0;
    for (int i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
      if (fe_slot_valid_i[i]) begin
        cmp_instrs[cmp_cnt] = fe_instrs_i[i];
        cmp_pcs[cmp_cnt]    = fe_pc_i + fe_pkg::PLEN'((fe_pkg::ILEN / 8) * i);
        cmp_cnt             = cmp_cnt + 1'b1;
      end
    end
  end

  // whole group or nothing
  assign fe_ready_o = !flush_i && (CNT_W'(IB_DEPTH) - count_q >= cmp_cnt);
  assign fe_fire    = fe_valid_i && fe_ready_o;
  assign push_cnt   = fe_fire ? cmp_cnt : '0;
  assign avail_cnt  = count_q + push_cnt;
  assign out_cnt    = (avail_cnt > CNT_W'(fe_pkg::DECODE_WIDTH)) ?
                      CNT_W'(fe_pkg::DECODE_WIDTH) : avail_cnt;

  assign ibuf_valid_o = !flush_i && (out_cnt != '0);
  assign pop_cnt      = (ibuf_valid_o && ibuf_ready_i) ? out_cnt : '0;
  // older entries leave first, the rest comes from the incoming group
  assign pop_q_cnt    = (pop_cnt > count_q) ? count_q : pop_cnt;
  assign byp_cnt      = pop_cnt - pop_q_cnt;
  assign push_q_cnt   = push_cnt - byp_cnt;

  always_comb begin
    for (int j = 0; j < fe_pkg::DECODE_WIDTH; j++) begin
      ibuf_slot_valid_o[j] = ibuf_valid_o && (CNT_W'(j) < out_cnt);
      if (CNT_W'(j) < count_q) begin
        ibuf_instrs_o[j] = instr_mem[rd_ptr_q + PTR_W'(j)];
        ibuf_pcs_o[j]    = pc_mem[rd_ptr_q + PTR_W'(j)];
      end else begin
        ibuf_instrs_o[j] = cmp_instrs[CNT_W'(j) - count_q];
        ibuf_pcs_o[j]    = cmp_pcs[CNT_W'(j) - count_q];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(push_q_cnt);
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop_q_cnt);
      count_q  <= count_q + push_q_cnt - pop_q_cnt;
    end
  end

  // only the slots not already bypassed get stored
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < fe_pkg::FETCH_WIDTH; i++) begin
      if (!flush_i && (CNT_W'(i) < push_q_cnt)) begin
        instr_mem[wr_ptr_q + PTR_W'(i)] <= cmp_instrs[byp_cnt + CNT_W'(i)];
        pc_mem[wr_ptr_q + PTR_W'(i)]    <= cmp_pcs[byp_cnt + CNT_W'(i)];
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(IB_DEPTH));

endmodule

/* verilog/imem_arbiter.sv */
// fixed-priority arbiter sharing the instruction memory port between loader and fetch
module imem_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             load_valid_i,
  input  logic [fe_pkg::ROW_AW-1:0]                        load_row_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] load_data_i,
  input  logic                                             fetch_req_i,
  input  logic [fe_pkg::ROW_AW-1:0]                        fetch_row_i,
  output logic                                             load_ready_o,
  output logic                                             fetch_gnt_o,
  output logic                                             rvalid_o,
  output logic                                             mem_en_o,
  output logic                                             mem_we_o,
  output logic [fe_pkg::ROW_AW-1:0]                        mem_row_o,
  output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] mem_wdata_o
);

  // loader always wins and its write is taken the same cycle
  assign load_ready_o = load_valid_i;
  assign fetch_gnt_o  = fetch_req_i && !load_valid_i;

  assign mem_en_o    = load_valid_i || fetch_gnt_o;
  assign mem_we_o    = load_valid_i;
  assign mem_row_o   = load_valid_i ? load_row_i : fetch_row_i;
  assign mem_wdata_o = load_data_i;

  // granted fetch read returns one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= fetch_gnt_o;
    end
  end

endmodule

/* verilog/inst_mem.sv */
// single-port instruction row memory, written by the loader and read by fetch
module inst_mem (
  input  logic                                             clk_i,
  input  logic                                             en_i,
  input  logic                                             we_i,
  input  logic [fe_pkg::ROW_AW-1:0]                        row_i,
  input  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] wdata_i,
  output logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rdata_o
);

  logic [fe_pkg::FETCH_WIDTH-1:0][fe_pkg::ILEN-1:0] rows_q [fe_pkg::MEM_ROWS];

  // read data shows up the cycle after the access
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        rows_q[row_i] <= wdata_i;
      end else begin
        rdata_o <= rows_q[row_i];
      end
    end
  end

  // the arbiter must never hand over a floating row address
  a_row_known: assert property (@(posedge clk_i) en_i |-> !$isunknown(row_i));

endmodule
